/* rtl/udp_hdr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP and IPv4 header field widths for the echo core
// Only the fields the echo path touches are listed
// Checksum, TTL and the local source IP are filled in downstream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package udp_hdr_pkg;

    // UDP port number
    localparam int PORT_W = 16;

    // UDP length field, header plus payload in bytes
    localparam int LEN_W = 16;

    // IPv4 address
    localparam int IP_ADDR_W = 32;

    // Port answered when the top level is left at its default
    localparam logic [PORT_W-1:0] DEFAULT_ECHO_PORT = 16'd1234;

endpackage

`default_nettype wire

/* rtl/axis_beat_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Payload beat geometry for the echo datapath
// One keep bit per byte lane
// BYTE_W also sets the LED width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package axis_beat_pkg;

    // Width of one byte lane
    localparam int BYTE_W = 8;

    // Width of a payload beat
    localparam int DATA_W = 64;

    // Byte enables per beat
    localparam int KEEP_W = DATA_W / BYTE_W;

endpackage

`default_nettype wire

/* rtl/echo_port_filter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-datagram echo or drop decision
// Verdict is taken when the header is accepted
// Matching headers wait for a free header slot
// Dropped payload is drained at full rate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module echo_port_filter #(
    parameter logic [udp_hdr_pkg::PORT_W-1:0] ECHO_PORT = udp_hdr_pkg::DEFAULT_ECHO_PORT
) (
    input  wire                            clk,
    input  wire                            rst,

    input  wire                            rx_hdr_valid,
    output logic                           rx_hdr_ready,
    input  wire [udp_hdr_pkg::PORT_W-1:0]  rx_udp_dest_port,

    input  wire                            hdr_slot_free,
    output logic                           hdr_load,

    input  wire                            rx_payload_valid,
    output logic                           rx_payload_ready,
    input  wire                            rx_payload_last,

    input  wire                            fifo_wr_ready,
    output logic                           fifo_wr_en
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_PASS = 2'd1;
    localparam logic [1:0] ST_DROP = 2'd2;

    logic [1:0] state;
    logic       port_match;
    logic       hdr_xfer;
    logic       last_xfer;

    assign port_match = rx_udp_dest_port == ECHO_PORT;

    // Non-matching headers never wait on the header slot
    assign rx_hdr_ready = (state == ST_IDLE) && (!port_match || hdr_slot_free);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_xfer && port_match;

    assign rx_payload_ready = (state == ST_DROP) || ((state == ST_PASS) && fifo_wr_ready);
    assign fifo_wr_en       = (state == ST_PASS) && rx_payload_valid && fifo_wr_ready;
    assign last_xfer        = rx_payload_valid && rx_payload_ready && rx_payload_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ST_PASS : ST_DROP;
                    end
                end
                ST_PASS, ST_DROP: begin
                    if (last_xfer) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Header builder must claim the slot, or the next reply would overwrite it
    hdr_load_slot_taken: assert property (
        @(posedge clk) disable iff (rst)
        hdr_load |=> !hdr_slot_free
    ) else $error("header slot still free after hdr_load");

endmodule

`default_nettype wire

/* rtl/echo_header_builder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-entry reply header register
// Ports are swapped, sender IP becomes the destination
// UDP length passes through unchanged
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module echo_header_builder (
    input  wire                               clk,
    input  wire                               rst,

    input  wire                               hdr_load,
    input  wire [udp_hdr_pkg::IP_ADDR_W-1:0]  rx_ip_source_ip,
    input  wire [udp_hdr_pkg::PORT_W-1:0]     rx_udp_source_port,
    input  wire [udp_hdr_pkg::PORT_W-1:0]     rx_udp_dest_port,
    input  wire [udp_hdr_pkg::LEN_W-1:0]      rx_udp_length,
    output logic                              hdr_slot_free,

    output logic                              tx_hdr_valid,
    input  wire                               tx_hdr_ready,
    output logic [udp_hdr_pkg::IP_ADDR_W-1:0] tx_ip_dest_ip,
    output logic [udp_hdr_pkg::PORT_W-1:0]    tx_udp_source_port,
    output logic [udp_hdr_pkg::PORT_W-1:0]    tx_udp_dest_port,
    output logic [udp_hdr_pkg::LEN_W-1:0]     tx_udp_length
);

    assign hdr_slot_free = !tx_hdr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // Reply fields
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            tx_ip_dest_ip      <= rx_ip_source_ip;
            tx_udp_source_port <= rx_udp_dest_port;
            tx_udp_dest_port   <= rx_udp_source_port;
            tx_udp_length      <= rx_udp_length;
        end
    end

    hdr_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid &&
            $stable({tx_ip_dest_ip, tx_udp_source_port, tx_udp_dest_port, tx_udp_length})
    ) else $error("reply header changed while stalled");

endmodule

`default_nettype wire

/* rtl/payload_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous payload FIFO with registered output
// FIFO_DEPTH must be a power of two, at least 2
// Holds FIFO_DEPTH beats plus one in the output register
// A write shows at the output one clock after it lands
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module payload_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  wire                              clk,
    input  wire                              rst,

    input  wire                              fifo_wr_en,
    output logic                             fifo_wr_ready,
    input  wire [axis_beat_pkg::DATA_W-1:0]  wr_data,
    input  wire [axis_beat_pkg::KEEP_W-1:0]  wr_keep,
    input  wire                              wr_last,
    input  wire                              wr_user,

    output logic                             rd_valid,
    input  wire                              rd_ready,
    output logic [axis_beat_pkg::DATA_W-1:0] rd_data,
    output logic [axis_beat_pkg::KEEP_W-1:0] rd_keep,
    output logic                             rd_last,
    output logic                             rd_user
);

    localparam int ADDR_W  = $clog2(FIFO_DEPTH);
    localparam int ENTRY_W = axis_beat_pkg::DATA_W + axis_beat_pkg::KEEP_W + 2;

    // Data, keep, last and user share one entry
    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [ENTRY_W-1:0] wr_word;
    logic [ENTRY_W-1:0] out_word;

    // Extra top bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic mem_empty;
    logic mem_full;
    logic out_load;

    assign wr_word = {wr_user, wr_last, wr_keep, wr_data};

    assign mem_empty = wr_ptr == rd_ptr;
    assign mem_full  = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &&
                       (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

    assign fifo_wr_ready = !mem_full;

    // Refill the output register when it is empty or being read
    assign out_load = !mem_empty && (!rd_valid || rd_ready);

    always_ff @(posedge clk) begin
        if (fifo_wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_word;
        end
        if (out_load) begin
            out_word <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (fifo_wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_load) begin
                rd_ptr   <= rd_ptr + 1'b1;
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
        end
    end

    assign {rd_user, rd_last, rd_keep, rd_data} = out_word;

    // Writer has to respect fifo_wr_ready
    no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        fifo_wr_en |-> !mem_full
    ) else $error("payload FIFO written while full");

endmodule

`default_nettype wire

/* rtl/led_byte_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Latches byte 0 of each outgoing first beat
// Datagram start is tracked from last flags
// led updates one cycle after that beat transfers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module led_byte_capture (
    input  wire                              clk,
    input  wire                              rst,

    input  wire                              tx_payload_valid,
    input  wire                              tx_payload_ready,
    input  wire                              tx_payload_last,
    input  wire [axis_beat_pkg::BYTE_W-1:0]  tx_payload_byte0,

    output logic [axis_beat_pkg::BYTE_W-1:0] led
);

    // Set while the next beat opens a datagram
    logic sof;
    logic beat_xfer;

    assign beat_xfer = tx_payload_valid && tx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            sof <= 1'b1;
            led <= '0;
        end else if (beat_xfer) begin
            sof <= tx_payload_last;
            if (sof) begin
                led <= tx_payload_byte0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/udp_echo_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP echo core behind an already parsed UDP stack
// Echoes datagrams sent to ECHO_PORT, drops all others
// One header and one payload burst per datagram
// FIFO_DEPTH must be a power of two, at least 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module udp_echo_core #(
    parameter logic [udp_hdr_pkg::PORT_W-1:0] ECHO_PORT = udp_hdr_pkg::DEFAULT_ECHO_PORT,
    parameter int FIFO_DEPTH = 64
) (
    input  wire                               clk,
    input  wire                               rst,

    // Receive header
    input  wire                               rx_hdr_valid,
    output wire                               rx_hdr_ready,
    input  wire [udp_hdr_pkg::IP_ADDR_W-1:0]  rx_ip_source_ip,
    input  wire [udp_hdr_pkg::PORT_W-1:0]     rx_udp_source_port,
    input  wire [udp_hdr_pkg::PORT_W-1:0]     rx_udp_dest_port,
    input  wire [udp_hdr_pkg::LEN_W-1:0]      rx_udp_length,

    // Receive payload
    input  wire                               rx_payload_valid,
    output wire                               rx_payload_ready,
    input  wire [axis_beat_pkg::DATA_W-1:0]   rx_payload_data,
    input  wire [axis_beat_pkg::KEEP_W-1:0]   rx_payload_keep,
    input  wire                               rx_payload_last,
    input  wire                               rx_payload_user,

    // Transmit header
    output wire                               tx_hdr_valid,
    input  wire                               tx_hdr_ready,
    output wire [udp_hdr_pkg::IP_ADDR_W-1:0]  tx_ip_dest_ip,
    output wire [udp_hdr_pkg::PORT_W-1:0]     tx_udp_source_port,
    output wire [udp_hdr_pkg::PORT_W-1:0]     tx_udp_dest_port,
    output wire [udp_hdr_pkg::LEN_W-1:0]      tx_udp_length,

    // Transmit payload
    output wire                               tx_payload_valid,
    input  wire                               tx_payload_ready,
    output wire [axis_beat_pkg::DATA_W-1:0]   tx_payload_data,
    output wire [axis_beat_pkg::KEEP_W-1:0]   tx_payload_keep,
    output wire                               tx_payload_last,
    output wire                               tx_payload_user,

    output wire [axis_beat_pkg::BYTE_W-1:0]   led
);

    wire hdr_load;
    wire hdr_slot_free;
    wire fifo_wr_en;
    wire fifo_wr_ready;

    echo_port_filter #(
        .ECHO_PORT(ECHO_PORT)
    ) echo_port_filter_i (
        .clk(clk),
        .rst(rst),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_udp_dest_port(rx_udp_dest_port),
        .hdr_slot_free(hdr_slot_free),
        .hdr_load(hdr_load),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .rx_payload_last(rx_payload_last),
        .fifo_wr_ready(fifo_wr_ready),
        .fifo_wr_en(fifo_wr_en)
    );

    echo_header_builder echo_header_builder_i (
        .clk(clk),
        .rst(rst),
        .hdr_load(hdr_load),
        .rx_ip_source_ip(rx_ip_source_ip),
        .rx_udp_source_port(rx_udp_source_port),
        .rx_udp_dest_port(rx_udp_dest_port),
        .rx_udp_length(rx_udp_length),
        .hdr_slot_free(hdr_slot_free),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_ip_dest_ip(tx_ip_dest_ip),
        .tx_udp_source_port(tx_udp_source_port),
        .tx_udp_dest_port(tx_udp_dest_port),
        .tx_udp_length(tx_udp_length)
    );

    payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) payload_fifo_i (
        .clk(clk),
        .rst(rst),
        .fifo_wr_en(fifo_wr_en),
        .fifo_wr_ready(fifo_wr_ready),
        .wr_data(rx_payload_data),
        .wr_keep(rx_payload_keep),
        .wr_last(rx_payload_last),
        .wr_user(rx_payload_user),
        .rd_valid(tx_payload_valid),
        .rd_ready(tx_payload_ready),
        .rd_data(tx_payload_data),
        .rd_keep(tx_payload_keep),
        .rd_last(tx_payload_last),
        .rd_user(tx_payload_user)
    );

    // LED follows the transmit side, so only echoed datagrams show up
    led_byte_capture led_byte_capture_i (
        .clk(clk),
        .rst(rst),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .tx_payload_last(tx_payload_last),
        .tx_payload_byte0(tx_payload_data[axis_beat_pkg::BYTE_W-1:0]),
        .led(led)
    );

endmodule

`default_nettype wire

/* verification/echo_scoreboard.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model and checker for the UDP echo core
// Samples every handshake on the falling clock edge
// Inputs must be driven away from the falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module echo_scoreboard #(
    parameter logic [udp_hdr_pkg::PORT_W-1:0] ECHO_PORT = 16'd1234
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               rx_hdr_valid,
    input  wire                               rx_hdr_ready,
    input  wire [udp_hdr_pkg::IP_ADDR_W-1:0]  rx_ip_source_ip,
    input  wire [udp_hdr_pkg::PORT_W-1:0]     rx_udp_source_port,
    input  wire [udp_hdr_pkg::PORT_W-1:0]     rx_udp_dest_port,
    input  wire [udp_hdr_pkg::LEN_W-1:0]      rx_udp_length,
    input  wire                               rx_payload_valid,
    input  wire                               rx_payload_ready,
    input  wire [axis_beat_pkg::DATA_W-1:0]   rx_payload_data,
    input  wire [axis_beat_pkg::KEEP_W-1:0]   rx_payload_keep,
    input  wire                               rx_payload_last,
    input  wire                               rx_payload_user,
    input  wire                               tx_hdr_valid,
    input  wire                               tx_hdr_ready,
    input  wire [udp_hdr_pkg::IP_ADDR_W-1:0]  tx_ip_dest_ip,
    input  wire [udp_hdr_pkg::PORT_W-1:0]     tx_udp_source_port,
    input  wire [udp_hdr_pkg::PORT_W-1:0]     tx_udp_dest_port,
    input  wire [udp_hdr_pkg::LEN_W-1:0]      tx_udp_length,
    input  wire                               tx_payload_valid,
    input  wire                               tx_payload_ready,
    input  wire [axis_beat_pkg::DATA_W-1:0]   tx_payload_data,
    input  wire [axis_beat_pkg::KEEP_W-1:0]   tx_payload_keep,
    input  wire                               tx_payload_last,
    input  wire                               tx_payload_user,
    input  wire [axis_beat_pkg::BYTE_W-1:0]   led,
    output int                                hdr_checked,
    output int                                beat_checked,
    output int                                stall_count,
    output int                                error_count,
    output int                                pending
);

    localparam int HDR_W  = udp_hdr_pkg::IP_ADDR_W + 2 * udp_hdr_pkg::PORT_W +
                            udp_hdr_pkg::LEN_W;
    localparam int BEAT_W = axis_beat_pkg::DATA_W + axis_beat_pkg::KEEP_W + 2;

    logic [HDR_W-1:0]  hdr_q [$];
    logic [BEAT_W-1:0] beat_q [$];
    logic [HDR_W-1:0]  exp_hdr;
    logic [HDR_W-1:0]  act_hdr;
    logic [HDR_W-1:0]  held_hdr;
    logic [BEAT_W-1:0] exp_beat;
    logic [BEAT_W-1:0] act_beat;
    logic [axis_beat_pkg::BYTE_W-1:0] exp_led;
    logic in_echo;
    logic in_drop;
    logic held;
    logic sof;

    assign act_hdr  = {tx_ip_dest_ip, tx_udp_source_port, tx_udp_dest_port, tx_udp_length};
    assign act_beat = {tx_payload_user, tx_payload_last, tx_payload_keep, tx_payload_data};

    always @(negedge clk) begin
        if (rst) begin
            hdr_q.delete();
            beat_q.delete();
            in_echo = 1'b0;
            in_drop = 1'b0;
            held = 1'b0;
            sof = 1'b1;
            exp_led = '0;
            hdr_checked = 0;
            beat_checked = 0;
            stall_count = 0;
            error_count = 0;
        end else begin
            // LED reflects transfers up to the last rising edge
            if (led !== exp_led) begin
                $display("Error led_byte0 expected %h actual %h", exp_led, led);
                error_count++;
            end
            if (held && !tx_hdr_valid) begin
                $display("Reply header valid dropped before its transfer");
                error_count++;
            end else if (held && act_hdr !== held_hdr) begin
                $display("Error hdr_hold expected %h actual %h", held_hdr, act_hdr);
                error_count++;
            end
            held = tx_hdr_valid && !tx_hdr_ready;
            held_hdr = act_hdr;

            // Receive side, builds the expected queues
            if (rx_hdr_valid && rx_hdr_ready) begin
                if (rx_udp_dest_port == ECHO_PORT) begin
                    hdr_q.push_back({rx_ip_source_ip, rx_udp_dest_port,
                                     rx_udp_source_port, rx_udp_length});
                    in_echo = 1'b1;
                end else begin
                    in_drop = 1'b1;
                end
            end
            if (in_drop && rx_payload_valid && !rx_payload_ready) begin
                $display("Payload of a dropped datagram was back-pressured");
                error_count++;
            end
            if (in_echo && rx_payload_valid && !rx_payload_ready) begin
                stall_count++;
            end
            if (rx_payload_valid && rx_payload_ready) begin
                if (in_echo) begin
                    beat_q.push_back({rx_payload_user, rx_payload_last,
                                      rx_payload_keep, rx_payload_data});
                end
                if (rx_payload_last) begin
                    in_echo = 1'b0;
                    in_drop = 1'b0;
                end
            end

            // Transmit side
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    $display("Reply header sent with no echoed datagram pending");
                    error_count++;
                end else begin
                    exp_hdr = hdr_q.pop_front();
                    hdr_checked++;
                    if (act_hdr !== exp_hdr) begin
                        $display("Error reply_header expected %h actual %h", exp_hdr, act_hdr);
                        error_count++;
                    end
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (beat_q.size() == 0) begin
                    $display("Payload beat sent with no echoed beat pending");
                    error_count++;
                end else begin
                    exp_beat = beat_q.pop_front();
                    beat_checked++;
                    if (act_beat !== exp_beat) begin
                        $display("Error payload_beat expected %h actual %h", exp_beat, act_beat);
                        error_count++;
                    end
                end
                if (sof) begin
                    exp_led = tx_payload_data[axis_beat_pkg::BYTE_W-1:0];
                end
                sof = tx_payload_last;
            end
        end
        pending = hdr_q.size() + beat_q.size();
    end

endmodule

`default_nettype wire

/* verification/tb_udp_echo_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the UDP echo core
// Random datagrams, about half to the echo port
// Random back-pressure on both transmit readies
// Inputs change 1 ns after the rising edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tb_udp_echo_core;

    localparam int CLK_PERIOD_NS   = 4;
    localparam int NUM_DGRAMS      = 200;
    localparam int MAX_BEATS       = 12;
    localparam int CYCLES_PER_BEAT = 40;
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam longint WATCHDOG_NS = longint'(NUM_DGRAMS) * MAX_BEATS * CYCLES_PER_BEAT *
                                     CLK_PERIOD_NS;

    logic        clk;
    logic        rst;
    logic        rx_hdr_valid;
    wire         rx_hdr_ready;
    logic [31:0] rx_ip_source_ip;
    logic [15:0] rx_udp_source_port;
    logic [15:0] rx_udp_dest_port;
    logic [15:0] rx_udp_length;
    logic        rx_payload_valid;
    wire         rx_payload_ready;
    logic [63:0] rx_payload_data;
    logic [7:0]  rx_payload_keep;
    logic        rx_payload_last;
    logic        rx_payload_user;
    wire         tx_hdr_valid;
    logic        tx_hdr_ready;
    wire  [31:0] tx_ip_dest_ip;
    wire  [15:0] tx_udp_source_port;
    wire  [15:0] tx_udp_dest_port;
    wire  [15:0] tx_udp_length;
    wire         tx_payload_valid;
    logic        tx_payload_ready;
    wire  [63:0] tx_payload_data;
    wire  [7:0]  tx_payload_keep;
    wire         tx_payload_last;
    wire         tx_payload_user;
    wire  [7:0]  led;

    int hdr_checked;
    int beat_checked;
    int stall_count;
    int sb_errors;
    int pending;
    int local_errors;
    int seed;

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    udp_echo_core #(
        .ECHO_PORT(ECHO_PORT),
        .FIFO_DEPTH(8)
    ) udp_echo_core_i (
        .clk(clk), .rst(rst),
        .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_ip_source_ip(rx_ip_source_ip), .rx_udp_source_port(rx_udp_source_port),
        .rx_udp_dest_port(rx_udp_dest_port), .rx_udp_length(rx_udp_length),
        .rx_payload_valid(rx_payload_valid), .rx_payload_ready(rx_payload_ready),
        .rx_payload_data(rx_payload_data), .rx_payload_keep(rx_payload_keep),
        .rx_payload_last(rx_payload_last), .rx_payload_user(rx_payload_user),
        .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
        .tx_ip_dest_ip(tx_ip_dest_ip), .tx_udp_source_port(tx_udp_source_port),
        .tx_udp_dest_port(tx_udp_dest_port), .tx_udp_length(tx_udp_length),
        .tx_payload_valid(tx_payload_valid), .tx_payload_ready(tx_payload_ready),
        .tx_payload_data(tx_payload_data), .tx_payload_keep(tx_payload_keep),
        .tx_payload_last(tx_payload_last), .tx_payload_user(tx_payload_user),
        .led(led)
    );

    echo_scoreboard #(
        .ECHO_PORT(ECHO_PORT)
    ) echo_scoreboard_i (
        .clk(clk), .rst(rst),
        .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_ip_source_ip(rx_ip_source_ip), .rx_udp_source_port(rx_udp_source_port),
        .rx_udp_dest_port(rx_udp_dest_port), .rx_udp_length(rx_udp_length),
        .rx_payload_valid(rx_payload_valid), .rx_payload_ready(rx_payload_ready),
        .rx_payload_data(rx_payload_data), .rx_payload_keep(rx_payload_keep),
        .rx_payload_last(rx_payload_last), .rx_payload_user(rx_payload_user),
        .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
        .tx_ip_dest_ip(tx_ip_dest_ip), .tx_udp_source_port(tx_udp_source_port),
        .tx_udp_dest_port(tx_udp_dest_port), .tx_udp_length(tx_udp_length),
        .tx_payload_valid(tx_payload_valid), .tx_payload_ready(tx_payload_ready),
        .tx_payload_data(tx_payload_data), .tx_payload_keep(tx_payload_keep),
        .tx_payload_last(tx_payload_last), .tx_payload_user(tx_payload_user),
        .led(led),
        .hdr_checked(hdr_checked), .beat_checked(beat_checked),
        .stall_count(stall_count), .error_count(sb_errors), .pending(pending)
    );

    // Advance n cycles, ending in the drive slot
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task send_header(input logic [31:0] src_ip, input logic [15:0] src_port,
                     input logic [15:0] dst_port, input logic [15:0] length);
        rx_hdr_valid = 1'b1;
        rx_ip_source_ip = src_ip;
        rx_udp_source_port = src_port;
        rx_udp_dest_port = dst_port;
        rx_udp_length = length;
        do @(negedge clk); while (!rx_hdr_ready);
        @(posedge clk);
        #1;
        rx_hdr_valid = 1'b0;
    endtask

    task send_beat(input logic [63:0] data, input logic [7:0] keep,
                   input logic last, input logic user);
        rx_payload_valid = 1'b1;
        rx_payload_data = data;
        rx_payload_keep = keep;
        rx_payload_last = last;
        rx_payload_user = user;
        do @(negedge clk); while (!rx_payload_ready);
        @(posedge clk);
        #1;
        rx_payload_valid = 1'b0;
    endtask

    task send_datagram;
        int nbeats;
        logic [15:0] dst_port;
        logic [7:0]  last_keep;
        logic [15:0] length;
        nbeats = $urandom_range(1, MAX_BEATS);
        last_keep = $urandom_range(1, 255);
        if ($urandom_range(0, 1) == 1) begin
            dst_port = ECHO_PORT;
        end else begin
            dst_port = $urandom_range(0, 65535);
        end
        // UDP length counts the 8 header bytes too
        length = 16'(8 + 8 * (nbeats - 1) + $countones(last_keep));
        idle($urandom_range(0, 3));
        send_header($urandom, 16'($urandom_range(0, 65535)), dst_port, length);
        for (int i = 0; i < nbeats; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                idle(1);
            end
            send_beat({$urandom, $urandom}, (i == nbeats - 1) ? last_keep : 8'hff,
                      i == nbeats - 1, 1'($urandom_range(0, 1)));
        end
    endtask

    task pace_hdr_ready;
        int high_cycles;
        int low_cycles;
        forever begin
            high_cycles = $urandom_range(1, 8);
            low_cycles = $urandom_range(1, 10);
            tx_hdr_ready = 1'b1;
            idle(high_cycles);
            tx_hdr_ready = 1'b0;
            idle(low_cycles);
        end
    endtask

    // Long low stretches let the 8-entry FIFO fill up
    task pace_payload_ready;
        int high_cycles;
        int low_cycles;
        forever begin
            high_cycles = $urandom_range(1, 10);
            low_cycles = $urandom_range(1, 20);
            tx_payload_ready = 1'b1;
            idle(high_cycles);
            tx_payload_ready = 1'b0;
            idle(low_cycles);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_ip_source_ip = '0;
        rx_udp_source_port = '0;
        rx_udp_dest_port = '0;
        rx_udp_length = '0;
        rx_payload_valid = 1'b0;
        rx_payload_data = '0;
        rx_payload_keep = '0;
        rx_payload_last = 1'b0;
        rx_payload_user = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_payload_ready = 1'b0;
        local_errors = 0;
        seed = 32'h5d34;
        void'($urandom(seed));
        idle(4);
        rst = 1'b0;
        if ({tx_hdr_valid, tx_payload_valid, led} !== 10'h0) begin
            $display("Error reset_state expected %h actual %h", 10'h0,
                     {tx_hdr_valid, tx_payload_valid, led});
            local_errors++;
        end
        fork
            pace_hdr_ready();
            pace_payload_ready();
        join_none
        repeat (NUM_DGRAMS) begin
            send_datagram();
        end
        wait (pending == 0);
        @(negedge clk);
        if (tx_hdr_valid || tx_payload_valid) begin
            $display("Outputs still valid after all echoed data was sent");
            local_errors++;
        end
        if (stall_count == 0) begin
            $display("Payload FIFO never filled during the run");
            local_errors++;
        end
        $display("Summary: %0d reply headers, %0d payload beats checked, %0d errors",
                 hdr_checked, beat_checked, sb_errors + local_errors);
        if (sb_errors + local_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* udp_echo_core.f */
rtl/udp_hdr_pkg.sv
rtl/axis_beat_pkg.sv
rtl/echo_port_filter.sv
rtl/echo_header_builder.sv
rtl/payload_fifo.sv
rtl/led_byte_capture.sv
rtl/udp_echo_core.sv
verification/echo_scoreboard.sv
verification/tb_udp_echo_core.sv
